// File: mini_mcu_pkg.sv
// shared widths, opcode encoding and core states for the mini MCU
// modules refer to these by scoped name, no import

package mini_mcu_pkg;

  // bus and memory geometry
  localparam int data_width = 32;
  localparam int addr_width = 8;

  // instruction word layout
  localparam int op_msb    = 31;
  localparam int op_lsb    = 28;
  localparam int imm_lsb   = 0;
  localparam int imm_width = 16;
  // operand address sits in the low bits
  localparam int arg_lsb   = 0;

  // reported when the core decodes an unknown opcode
  localparam logic [data_width-1:0] illegal_exit_value = '1;

  typedef enum logic [3:0] {
    op_ldi  = 4'h1,
    op_add  = 4'h2,
    op_st   = 4'h3,
    op_exit = 4'hf
  } opcode_e;

  typedef enum logic [2:0] {
    idle       = 3'd0,
    fetch      = 3'd1,
    fetch_wait = 3'd2,
    exec_rd    = 3'd3,
    exec_wait  = 3'd4,
    halted     = 3'd5
  } core_state_e;

endpackage

// File: sram_bank.sv
`timescale 1ns/100ps
// single-port on-chip RAM, read data valid one cycle after the access
// a write returns the written word on rdata_o the next cycle

module sram_bank (
  input  logic                                clk_gen,
  input  logic                                en_i,
  input  logic                                we_i,
  input  logic [mini_mcu_pkg::addr_width-1:0] addr_i,
  input  logic [mini_mcu_pkg::data_width-1:0] wdata_i,
  output logic [mini_mcu_pkg::data_width-1:0] rdata_o
);

  localparam int depth = 1 << mini_mcu_pkg::addr_width;

  logic [mini_mcu_pkg::data_width-1:0] mem_q [0:depth-1];

  // write-first behaviour on the read port
  always_ff @(posedge clk_gen) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
        rdata_o       <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: bus_arbiter.sv
`timescale 1ns/100ps
// fixed-priority arbiter between boot loader and core in front of the RAM
// grants are combinational, read data is routed back one cycle later

module bus_arbiter (
  input  logic                                clk_gen,
  input  logic                                rst_n,
  // boot loader, write only
  input  logic                                ldr_req_i,
  input  logic [mini_mcu_pkg::addr_width-1:0] ldr_addr_i,
  input  logic [mini_mcu_pkg::data_width-1:0] ldr_wdata_i,
  output logic                                ldr_gnt_o,
  // core
  input  logic                                core_req_i,
  input  logic                                core_we_i,
  input  logic [mini_mcu_pkg::addr_width-1:0] core_addr_i,
  input  logic [mini_mcu_pkg::data_width-1:0] core_wdata_i,
  output logic                                core_gnt_o,
  output logic                                core_rvalid_o,
  output logic [mini_mcu_pkg::data_width-1:0] core_rdata_o,
  // RAM side
  output logic                                mem_en_o,
  output logic                                mem_we_o,
  output logic [mini_mcu_pkg::addr_width-1:0] mem_addr_o,
  output logic [mini_mcu_pkg::data_width-1:0] mem_wdata_o,
  input  logic [mini_mcu_pkg::data_width-1:0] mem_rdata_i
);

  logic core_rd_q;

  // loader always wins
  assign ldr_gnt_o  = ldr_req_i;
  assign core_gnt_o = core_req_i & ~ldr_req_i;

  assign mem_en_o    = ldr_gnt_o | core_gnt_o;
  assign mem_we_o    = ldr_gnt_o | (core_gnt_o & core_we_i);
  assign mem_addr_o  = ldr_gnt_o ? ldr_addr_i : core_addr_i;
  assign mem_wdata_o = ldr_gnt_o ? ldr_wdata_i : core_wdata_i;

  // owner of the read in flight, only the core can read
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      core_rd_q <= 1'b0;
    end else begin
      core_rd_q <= core_gnt_o & ~core_we_i;
    end
  end

  assign core_rvalid_o = core_rd_q;
  assign core_rdata_o  = mem_rdata_i;

  a_one_grant: assert property (@(posedge clk_gen) disable iff (!rst_n)
    !(ldr_gnt_o && core_gnt_o))
    else $error("arbiter granted both masters in one cycle");

endmodule

// File: boot_loader.sv
`timescale 1ns/100ps
// turns pin load strobes into RAM write requests and starts the core
// one write can be pending, a strobe that finds it blocked is an overrun

module boot_loader (
  input  logic                                clk_gen,
  input  logic                                rst_n,
  input  logic                                load_valid_i,
  input  logic [mini_mcu_pkg::addr_width-1:0] load_addr_i,
  input  logic [mini_mcu_pkg::data_width-1:0] load_data_i,
  input  logic                                boot_go_i,
  input  logic                                gnt_i,
  output logic                                req_o,
  output logic [mini_mcu_pkg::addr_width-1:0] addr_o,
  output logic [mini_mcu_pkg::data_width-1:0] wdata_o,
  output logic                                load_overrun_o,
  output logic                                start_o
);

  logic                                pend_q;
  logic [mini_mcu_pkg::addr_width-1:0] addr_q;
  logic [mini_mcu_pkg::data_width-1:0] data_q;
  logic                                blocked;
  logic                                accept;

  // pending write still waiting for its grant
  assign blocked = pend_q & ~gnt_i;
  assign accept  = load_valid_i & ~blocked;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      pend_q         <= 1'b0;
      load_overrun_o <= 1'b0;
      start_o        <= 1'b0;
    end else begin
      if (accept) begin
        pend_q <= 1'b1;
      end else if (gnt_i) begin
        pend_q <= 1'b0;
      end
      if (load_valid_i && blocked) begin
        load_overrun_o <= 1'b1;
      end
      start_o <= boot_go_i;
    end
  end

  always_ff @(posedge clk_gen) begin
    if (accept) begin
      addr_q <= load_addr_i;
      data_q <= load_data_i;
    end
  end

  assign req_o   = pend_q;
  assign addr_o  = addr_q;
  assign wdata_o = data_q;

  a_req_held: assert property (@(posedge clk_gen) disable iff (!rst_n)
    req_o && !gnt_i |=> req_o && $stable(addr_o) && $stable(wdata_o))
    else $error("loader request changed before it was granted");

endmodule

// File: tiny_core.sv
`timescale 1ns/100ps
// accumulator core: fetch, decode and execute out of the shared RAM
// halts on op_exit or an unknown opcode and reports the exit word

module tiny_core #(
  parameter int BOOT_ADDR = 0
) (
  input  logic                                clk_gen,
  input  logic                                rst_n,
  input  logic                                start_i,
  input  logic                                gnt_i,
  input  logic                                rvalid_i,
  input  logic [mini_mcu_pkg::data_width-1:0] rdata_i,
  output logic                                req_o,
  output logic                                we_o,
  output logic [mini_mcu_pkg::addr_width-1:0] addr_o,
  output logic [mini_mcu_pkg::data_width-1:0] wdata_o,
  output logic                                exit_valid_o,
  output logic [mini_mcu_pkg::data_width-1:0] exit_value_o
);

  localparam logic [mini_mcu_pkg::addr_width-1:0] boot_pc =
    BOOT_ADDR[mini_mcu_pkg::addr_width-1:0];

  mini_mcu_pkg::core_state_e           state_q;
  mini_mcu_pkg::opcode_e               op_q;
  mini_mcu_pkg::opcode_e               op_dec;
  logic [mini_mcu_pkg::addr_width-1:0] pc_q;
  logic [mini_mcu_pkg::addr_width-1:0] opnd_q;
  logic [mini_mcu_pkg::data_width-1:0] acc_q;
  logic [mini_mcu_pkg::data_width-1:0] imm_ext;
  logic                                instr_in;

  // decode straight off the read bus
  assign op_dec  = mini_mcu_pkg::opcode_e'(rdata_i[mini_mcu_pkg::op_msb:mini_mcu_pkg::op_lsb]);
  assign imm_ext = {{(mini_mcu_pkg::data_width - mini_mcu_pkg::imm_width){1'b0}},
                    rdata_i[mini_mcu_pkg::imm_lsb +: mini_mcu_pkg::imm_width]};
  assign instr_in = (state_q == mini_mcu_pkg::fetch_wait) && rvalid_i;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= mini_mcu_pkg::idle;
      pc_q         <= boot_pc;
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else begin
      case (state_q)
        mini_mcu_pkg::idle: begin
          if (start_i) begin
            pc_q    <= boot_pc;
            state_q <= mini_mcu_pkg::fetch;
          end
        end
        mini_mcu_pkg::fetch: begin
          if (gnt_i) begin
            state_q <= mini_mcu_pkg::fetch_wait;
          end
        end
        mini_mcu_pkg::fetch_wait: begin
          if (rvalid_i) begin
            case (op_dec)
              mini_mcu_pkg::op_ldi: begin
                pc_q    <= pc_q + 1'b1;
                state_q <= mini_mcu_pkg::fetch;
              end
              mini_mcu_pkg::op_add, mini_mcu_pkg::op_st: begin
                state_q <= mini_mcu_pkg::exec_rd;
              end
              mini_mcu_pkg::op_exit: begin
                exit_valid_o <= 1'b1;
                exit_value_o <= acc_q;
                state_q      <= mini_mcu_pkg::halted;
              end
              default: begin
                exit_valid_o <= 1'b1;
                exit_value_o <= mini_mcu_pkg::illegal_exit_value;
                state_q      <= mini_mcu_pkg::halted;
              end
            endcase
          end
        end
        mini_mcu_pkg::exec_rd: begin
          // a store is done once granted, an add waits for data
          if (gnt_i) begin
            if (op_q == mini_mcu_pkg::op_st) begin
              pc_q    <= pc_q + 1'b1;
              state_q <= mini_mcu_pkg::fetch;
            end else begin
              state_q <= mini_mcu_pkg::exec_wait;
            end
          end
        end
        mini_mcu_pkg::exec_wait: begin
          if (rvalid_i) begin
            pc_q    <= pc_q + 1'b1;
            state_q <= mini_mcu_pkg::fetch;
          end
        end
        mini_mcu_pkg::halted: begin
          state_q <= mini_mcu_pkg::halted;
        end
        default: begin
          state_q <= mini_mcu_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_gen) begin
    if (instr_in) begin
      op_q   <= op_dec;
      opnd_q <= rdata_i[mini_mcu_pkg::arg_lsb +: mini_mcu_pkg::addr_width];
      if (op_dec == mini_mcu_pkg::op_ldi) begin
        acc_q <= imm_ext;
      end
    end else if ((state_q == mini_mcu_pkg::exec_wait) && rvalid_i) begin
      acc_q <= acc_q + rdata_i;
    end
  end

  assign req_o   = (state_q == mini_mcu_pkg::fetch) || (state_q == mini_mcu_pkg::exec_rd);
  assign we_o    = (state_q == mini_mcu_pkg::exec_rd) && (op_q == mini_mcu_pkg::op_st);
  assign addr_o  = (state_q == mini_mcu_pkg::fetch) ? pc_q : opnd_q;
  assign wdata_o = acc_q;

  // read data must only come back for a read this core is waiting on
  a_rvalid_expected: assert property (@(posedge clk_gen) disable iff (!rst_n)
    rvalid_i |-> (state_q inside {mini_mcu_pkg::fetch_wait, mini_mcu_pkg::exec_wait}))
    else $error("read data returned while core was not waiting");

endmodule

// File: fpga_wrapper.sv
`timescale 1ns/100ps
// board-level top: reset button polarity, status LEDs and the MCU subsystem
// loader and core share one RAM through the arbiter

module fpga_wrapper #(
  parameter int CLK_LED_COUNT_LENGTH = 27,
  parameter int RST_BTN_ACTIVE_LOW   = 0,
  parameter int BOOT_ADDR            = 0
) (
  input  logic                                clk_gen,
  input  logic                                rst_i,
  input  logic                                load_valid_i,
  input  logic [mini_mcu_pkg::addr_width-1:0] load_addr_i,
  input  logic [mini_mcu_pkg::data_width-1:0] load_data_i,
  input  logic                                boot_go_i,
  output logic                                rst_led_o,
  output logic                                clk_led_o,
  output logic                                load_overrun_o,
  output logic                                exit_valid_o,
  output logic [mini_mcu_pkg::data_width-1:0] exit_value_o
);

  logic                                rst_n;
  logic [CLK_LED_COUNT_LENGTH-1:0]     clk_count_q;
  logic                                core_start;
  logic                                ldr_req;
  logic                                ldr_gnt;
  logic [mini_mcu_pkg::addr_width-1:0] ldr_addr;
  logic [mini_mcu_pkg::data_width-1:0] ldr_wdata;
  logic                                core_req;
  logic                                core_we;
  logic                                core_gnt;
  logic                                core_rvalid;
  logic [mini_mcu_pkg::addr_width-1:0] core_addr;
  logic [mini_mcu_pkg::data_width-1:0] core_wdata;
  logic [mini_mcu_pkg::data_width-1:0] core_rdata;
  logic                                mem_en;
  logic                                mem_we;
  logic [mini_mcu_pkg::addr_width-1:0] mem_addr;
  logic [mini_mcu_pkg::data_width-1:0] mem_wdata;
  logic [mini_mcu_pkg::data_width-1:0] mem_rdata;

  // button is active high unless the board says otherwise
  assign rst_n     = (RST_BTN_ACTIVE_LOW != 0) ? rst_i : ~rst_i;
  assign rst_led_o = rst_n;

  // free-running blink counter
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];

  boot_loader boot_loader_i (
    .clk_gen, .rst_n, .load_valid_i, .load_addr_i, .load_data_i, .boot_go_i,
    .gnt_i(ldr_gnt), .req_o(ldr_req), .addr_o(ldr_addr), .wdata_o(ldr_wdata),
    .load_overrun_o, .start_o(core_start)
  );

  tiny_core #(.BOOT_ADDR(BOOT_ADDR)) tiny_core_i (
    .clk_gen, .rst_n, .start_i(core_start), .gnt_i(core_gnt),
    .rvalid_i(core_rvalid), .rdata_i(core_rdata), .req_o(core_req),
    .we_o(core_we), .addr_o(core_addr), .wdata_o(core_wdata),
    .exit_valid_o, .exit_value_o
  );

  bus_arbiter bus_arbiter_i (
    .clk_gen, .rst_n,
    .ldr_req_i(ldr_req), .ldr_addr_i(ldr_addr), .ldr_wdata_i(ldr_wdata),
    .ldr_gnt_o(ldr_gnt),
    .core_req_i(core_req), .core_we_i(core_we), .core_addr_i(core_addr),
    .core_wdata_i(core_wdata), .core_gnt_o(core_gnt),
    .core_rvalid_o(core_rvalid), .core_rdata_o(core_rdata),
    .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata)
  );

  sram_bank sram_bank_i (
    .clk_gen, .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .rdata_o(mem_rdata)
  );

endmodule

// File: tb_top.sv
`timescale 1ns/100ps
// testbench for the mini MCU wrapper: loads programs over the pin strobes,
// boots the core and checks the outputs with concurrent assertions

module tb_top;

  localparam int led_len        = 4;
  localparam int led_half       = 1 << (led_len - 1);
  localparam int clk_half       = 10;
  // the tests take a few hundred cycles, this leaves a wide margin
  localparam int timeout_cycles = 2000;

  logic        clk_gen;
  logic        rst_i;
  logic        load_valid_i;
  logic [7:0]  load_addr_i;
  logic [31:0] load_data_i;
  logic        boot_go_i;
  logic        rst_led_o;
  logic        clk_led_o;
  logic        load_overrun_o;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;

  int          errors    = 0;
  int          cycle_cnt = 0;
  int          since_rel = 0;
  integer      seed      = 32'h4cc8;
  string       test_name = "reset";
  logic [31:0] exp_exit  = '0;
  logic [31:0] rnd;
  logic [15:0] a_imm;
  logic [31:0] b_word;

  fpga_wrapper #(.CLK_LED_COUNT_LENGTH(led_len)) uut (
    .clk_gen, .rst_i, .load_valid_i, .load_addr_i, .load_data_i, .boot_go_i,
    .rst_led_o, .clk_led_o, .load_overrun_o, .exit_valid_o, .exit_value_o
  );

  initial begin
    clk_gen = 1'b0;
    forever #clk_half clk_gen = ~clk_gen;
  end

  // cycles since reset release, used for the led period
  always @(posedge clk_gen) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_i) begin
      since_rel <= 0;
    end else begin
      since_rel <= since_rel + 1;
    end
  end

  always @(posedge clk_gen) begin
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("errors: %0d", errors);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("** Error [%s] %s expected %0h actual %0h", test_name, sig, exp, act);
  endtask

  function automatic logic led_expected(input int cycles);
    return ((cycles / led_half) % 2) == 1;
  endfunction

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [15:0] arg);
    return {op, 12'h000, arg};
  endfunction

  a_rst_exit: assert property (@(posedge clk_gen)
    (cycle_cnt > 0) && (rst_i || $past(rst_i)) |-> !exit_valid_o)
    else report_mismatch("exit_valid_o", 32'd0, 32'($sampled(exit_valid_o)));

  a_rst_clk_led: assert property (@(posedge clk_gen)
    (cycle_cnt > 0) && (rst_i || $past(rst_i)) |-> !clk_led_o)
    else report_mismatch("clk_led_o", 32'd0, 32'($sampled(clk_led_o)));

  // button is active high, so the derived reset is its inverse
  a_rst_led: assert property (@(posedge clk_gen)
    (cycle_cnt > 0) |-> rst_led_o == !rst_i)
    else report_mismatch("rst_led_o", 32'(!$sampled(rst_i)), 32'($sampled(rst_led_o)));

  a_led_blink: assert property (@(posedge clk_gen)
    (cycle_cnt > 0) && !rst_i |-> clk_led_o == led_expected(since_rel))
    else report_mismatch("clk_led_o", 32'(led_expected($sampled(since_rel))),
                         32'($sampled(clk_led_o)));

  a_exit_value: assert property (@(posedge clk_gen)
    !rst_i && $rose(exit_valid_o) |-> exit_value_o == exp_exit)
    else report_mismatch("exit_value_o", exp_exit, $sampled(exit_value_o));

  a_exit_held: assert property (@(posedge clk_gen)
    (cycle_cnt > 0) && exit_valid_o && !rst_i |=> exit_valid_o || rst_i)
    else report_mismatch("exit_valid_o held", 32'd1, 32'($sampled(exit_valid_o)));

  a_no_overrun: assert property (@(posedge clk_gen)
    (cycle_cnt > 0) |-> !load_overrun_o)
    else report_mismatch("load_overrun_o", 32'd0, 32'($sampled(load_overrun_o)));

  task automatic write_word(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_gen);
    load_valid_i <= 1'b1;
    load_addr_i  <= addr;
    load_data_i  <= data;
  endtask

  task automatic end_load();
    @(posedge clk_gen);
    load_valid_i <= 1'b0;
  endtask

  // back-to-back strobes, one word per cycle
  task automatic load_program(input logic [15:0] imm, input logic [31:0] data);
    write_word(8'd0, encode(mini_mcu_pkg::op_ldi, imm));
    write_word(8'd1, encode(mini_mcu_pkg::op_add, 16'd100));
    write_word(8'd2, encode(mini_mcu_pkg::op_st, 16'd101));
    write_word(8'd3, encode(mini_mcu_pkg::op_add, 16'd101));
    write_word(8'd4, encode(mini_mcu_pkg::op_exit, 16'd0));
    write_word(8'd100, data);
    end_load();
  endtask

  task automatic stream_loads();
    logic [31:0] word;
    for (int a = 200; a < 256; a++) begin
      word = $random(seed);
      write_word(a[7:0], word);
      end_load();
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_gen);
    rst_i <= 1'b1;
    repeat (5) @(posedge clk_gen);
    rst_i <= 1'b0;
  endtask

  task automatic pulse_boot();
    @(posedge clk_gen);
    boot_go_i <= 1'b1;
    @(posedge clk_gen);
    boot_go_i <= 1'b0;
  endtask

  task automatic wait_exit();
    @(negedge clk_gen);
    while (!exit_valid_o) begin
      @(negedge clk_gen);
    end
  endtask

  initial begin
    rst_i        = 1'b1;
    load_valid_i = 1'b0;
    load_addr_i  = '0;
    load_data_i  = '0;
    boot_go_i    = 1'b0;
    repeat (5) @(posedge clk_gen);
    rst_i <= 1'b0;

    test_name = "led_blink";
    repeat (6 * led_half) @(posedge clk_gen);

    test_name = "program_run";
    rnd       = $random(seed);
    a_imm     = rnd[15:0];
    b_word    = $random(seed);
    exp_exit  = 2 * ({16'h0000, a_imm} + b_word);
    load_program(a_imm, b_word);
    pulse_boot();
    wait_exit();

    test_name = "back_to_back";
    for (int a = 200; a < 208; a++) begin
      write_word(a[7:0], 32'(a));
    end
    end_load();
    repeat (3) @(posedge clk_gen);

    // program stays in RAM, rerun it under loader traffic
    test_name = "contention";
    apply_reset();
    fork
      stream_loads();
      begin
        repeat (6) @(posedge clk_gen);
        pulse_boot();
      end
    join
    wait_exit();

    test_name = "illegal_opcode";
    exp_exit  = {32{1'b1}};
    // 4'h7 is not a defined opcode
    write_word(8'd0, encode(4'h7, 16'h0000));
    end_load();
    apply_reset();
    pulse_boot();
    wait_exit();
    repeat (4) @(posedge clk_gen);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: build.f
mini_mcu_pkg.sv
sram_bank.sv
bus_arbiter.sv
boot_loader.sv
tiny_core.sv
fpga_wrapper.sv
tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the mini MCU testbench with Verilator and runs it.
# The run counts as failed if the log holds the fail message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top \
  -f build.f -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

echo "simulation finished without failures"
